/* logic/gc_params.svh */
// Sizes shared by the control block, in-use table and TLBs; TLB depths must be powers of two
`ifndef GC_PARAMS_SVH
`define GC_PARAMS_SVH

////////////////////
// Register in-use table

// One busy bit per architectural register
`define GC_INUSE_DEPTH 32

////////////////////
// Translation

// Instruction TLB entries
`define GC_ITLB_DEPTH 4
// Data TLB entries
`define GC_DTLB_DEPTH 8
// Virtual and physical page number widths
`define GC_VPN_W 20
`define GC_PPN_W 22

`endif

/* logic/gc_types_pkg.sv */
// Control-side types; the op encoding is 3 bits wide and codes 6 and 7 have no effect
`default_nettype none

package gc_types_pkg;

    `include "gc_params.svh"

    // Index into the register in-use table
    typedef logic [$clog2(`GC_INUSE_DEPTH)-1:0] reg_addr_t;

    // Control instructions accepted while idle
    typedef enum logic [2:0] {
        OP_ECALL  = 3'd0,
        OP_EBREAK = 3'd1,
        OP_SRET   = 3'd2,
        OP_MRET   = 3'd3,
        OP_SFENCE = 3'd4,
        OP_FENCE  = 3'd5
    } gc_op_t;

    // Global control state machine
    typedef enum logic [2:0] {
        ST_RST,
        ST_PRE_CLEAR,
        ST_CLEAR,
        ST_IDLE,
        ST_TLB_CLEAR,
        ST_LS_POSSIBLE,
        ST_FENCE_WAIT
    } gc_state_t;

endpackage

`default_nettype wire

/* logic/tlb_types_pkg.sv */
// Translation-side types; payload layouts carry only the permission flags the TLBs return
`default_nettype none

package tlb_types_pkg;

    `include "gc_params.svh"

    // Page numbers
    typedef logic [`GC_VPN_W-1:0] vpn_t;
    typedef logic [`GC_PPN_W-1:0] ppn_t;

    // Instruction side payload, 23 bits
    typedef struct packed {
        ppn_t ppn;
        logic x;
    } itlb_entry_t;

    // Data side payload, 24 bits
    typedef struct packed {
        ppn_t ppn;
        logic r;
        logic w;
    } dtlb_entry_t;

endpackage

`default_nettype wire

/* logic/gc_interfaces.sv */
// In-use table write request; grant is combinational and a write lands on valid and grant
`timescale 1ns/1ps
`default_nettype none

interface inuse_wr_if import gc_types_pkg::*; ();

    ////////////////////
    // Request side

    // Write wanted this cycle
    logic      valid;
    // Table entry to write
    reg_addr_t addr;
    // Busy bit to store
    logic      value;

    ////////////////////
    // Arbiter side

    // Port owned this cycle
    logic      grant;

    modport requester (
        output valid,
        output addr,
        output value,
        input  grant
    );

    modport arbiter (
        input  valid,
        input  addr,
        input  value,
        output grant
    );

endinterface

`default_nettype wire

/* logic/gc_unit.sv */
// Global control FSM; ops are taken only in IDLE and a requester must hold gc_req until gc_ready
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_unit import gc_types_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   gc_req,
    input  gc_op_t gc_op,
    input  logic   ls_issue,
    input  logic   ls_fifo_emptying,
    input  logic   ls_fifo_empty,
    input  logic   itlb_busy,
    input  logic   dtlb_busy,
    output logic   gc_ready,
    output logic   ecall,
    output logic   ebreak,
    output logic   sret,
    output logic   mret,
    output logic   fetch_flush,
    output logic   fetch_hold,
    output logic   issue_hold,
    output logic   inorder,
    output logic   inuse_clear,
    output logic   tlb_flush,
    inuse_wr_if.requester clear_wr
);

    gc_state_t state;
    gc_state_t next_state;

    // Clear walker position
    reg_addr_t clear_addr;
    logic      clear_last;

    // Request accepted this cycle
    logic      idle_req;

    // Busy levels observed since entering TLB_CLEAR
    logic      itlb_seen;
    logic      dtlb_seen;
    logic      tlb_done;

    assign gc_ready   = (state == ST_IDLE);
    assign idle_req   = gc_ready && gc_req;
    assign clear_last = (clear_addr == reg_addr_t'(`GC_INUSE_DEPTH - 1));

    // Both walks started and both finished
    assign tlb_done = itlb_seen && dtlb_seen && !itlb_busy && !dtlb_busy;

    ////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_RST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RST: next_state = ST_PRE_CLEAR;
            ST_PRE_CLEAR: next_state = ST_CLEAR;
            // One table entry per cycle, top priority so always granted
            ST_CLEAR: begin
                if (clear_last && clear_wr.grant) begin
                    next_state = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (gc_req && gc_op == OP_SFENCE) begin
                    next_state = ST_TLB_CLEAR;
                end else if (gc_req && gc_op == OP_FENCE && !ls_fifo_empty) begin
                    // Already empty FIFO needs no wait
                    next_state = ST_FENCE_WAIT;
                end else if (ls_issue) begin
                    next_state = ST_LS_POSSIBLE;
                end
            end
            ST_TLB_CLEAR: begin
                if (tlb_done) begin
                    next_state = ST_IDLE;
                end
            end
            // A fresh load/store in the emptying cycle keeps the window open
            ST_LS_POSSIBLE: begin
                if (ls_fifo_emptying && !ls_issue) begin
                    next_state = ST_IDLE;
                end
            end
            ST_FENCE_WAIT: begin
                if (ls_fifo_empty) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_RST;
        endcase
    end

    ////////////////////
    // Registered outputs

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_hold  <= 1'b0;
            inuse_clear <= 1'b0;
            fetch_hold  <= 1'b0;
            inorder     <= 1'b0;
            ecall       <= 1'b0;
            ebreak      <= 1'b0;
            sret        <= 1'b0;
            mret        <= 1'b0;
            fetch_flush <= 1'b0;
            tlb_flush   <= 1'b0;
        end else begin
            // Levels follow the state being entered
            issue_hold  <= next_state inside {ST_PRE_CLEAR, ST_CLEAR, ST_TLB_CLEAR};
            inuse_clear <= (next_state == ST_CLEAR);
            fetch_hold  <= (next_state == ST_FENCE_WAIT);
            inorder     <= (next_state == ST_LS_POSSIBLE);
            // Single cycle strobes after the accepting edge
            ecall       <= idle_req && gc_op == OP_ECALL;
            ebreak      <= idle_req && gc_op == OP_EBREAK;
            sret        <= idle_req && gc_op == OP_SRET;
            mret        <= idle_req && gc_op == OP_MRET;
            fetch_flush <= idle_req &&
                           gc_op inside {OP_ECALL, OP_EBREAK, OP_SRET, OP_MRET, OP_SFENCE};
            tlb_flush   <= idle_req && gc_op == OP_SFENCE;
        end
    end

    ////////////////////
    // TLB walk tracking

    always_ff @(posedge clk) begin
        if (rst || state != ST_TLB_CLEAR) begin
            itlb_seen <= 1'b0;
            dtlb_seen <= 1'b0;
        end else begin
            itlb_seen <= itlb_seen || itlb_busy;
            dtlb_seen <= dtlb_seen || dtlb_busy;
        end
    end

    ////////////////////
    // Reset clear walker

    always_ff @(posedge clk) begin
        if (rst || state == ST_PRE_CLEAR) begin
            clear_addr <= '0;
        end else if (clear_wr.valid && clear_wr.grant) begin
            clear_addr <= clear_addr + reg_addr_t'(1);
        end
    end

    // Zeroes entries 0 upward for the whole of CLEAR
    assign clear_wr.valid = inuse_clear;
    assign clear_wr.addr  = clear_addr;
    assign clear_wr.value = 1'b0;

endmodule

`default_nettype wire

/* logic/inuse_write_arbiter.sv */
// Fixed priority for the single table write port; a losing requester must hold its request
`timescale 1ns/1ps
`default_nettype none

module inuse_write_arbiter import gc_types_pkg::*; (
    inuse_wr_if.arbiter clear_wr,
    inuse_wr_if.arbiter wb_wr,
    inuse_wr_if.arbiter issue_wr,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output logic      wr_value
);

    // Clear walker first, then writeback, then issue
    assign clear_wr.grant = clear_wr.valid;
    assign wb_wr.grant    = wb_wr.valid && !clear_wr.valid;
    assign issue_wr.grant = issue_wr.valid && !clear_wr.valid && !wb_wr.valid;

    assign wr_en = clear_wr.valid || wb_wr.valid || issue_wr.valid;

    // Forward the winner to the table port
    always_comb begin
        if (clear_wr.valid) begin
            wr_addr  = clear_wr.addr;
            wr_value = clear_wr.value;
        end else if (wb_wr.valid) begin
            wr_addr  = wb_wr.addr;
            wr_value = wb_wr.value;
        end else begin
            // Issue or nothing, wr_en covers the idle case
            wr_addr  = issue_wr.addr;
            wr_value = issue_wr.value;
        end
    end

endmodule

`default_nettype wire

/* logic/inuse_table.sv */
// Register busy bits; contents are undefined until the reset clear walk has run
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module inuse_table import gc_types_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  logic      wr_value,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output logic      rs1_busy,
    output logic      rs2_busy
);

    // One bit per register
    logic [`GC_INUSE_DEPTH-1:0] busy_bits;

    ////////////////////
    // Write port

    // Writes are dropped while reset is held
    always_ff @(posedge clk) begin
        if (wr_en && !rst) begin
            busy_bits[wr_addr] <= wr_value;
        end
    end

    ////////////////////
    // Read ports

    // Stored value only, a same cycle write shows up next cycle
    assign rs1_busy = busy_bits[rs1_addr];
    assign rs2_busy = busy_bits[rs2_addr];

endmodule

`default_nettype wire

/* logic/tlb.sv */
// Fully associative TLB; DEPTH must be a power of two and lookups see contents before a fill
`timescale 1ns/1ps
`default_nettype none

module tlb import tlb_types_pkg::*; #(
    parameter type ENTRY_T = logic,
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   lookup_valid,
    input  vpn_t   lookup_vpn,
    input  logic   fill_valid,
    input  vpn_t   fill_vpn,
    input  ENTRY_T fill_entry,
    output logic   busy,
    output logic   hit,
    output ENTRY_T entry
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0] valid;
    vpn_t             tags [DEPTH];
    ENTRY_T           data [DEPTH];

    // Round robin replacement pointer
    logic [IDX_W-1:0] victim;
    // Flush walk position
    logic [IDX_W-1:0] flush_idx;

    logic [IDX_W-1:0] fill_idx;
    logic             fill_match;
    logic             fill_do;
    logic [IDX_W-1:0] lookup_idx;
    logic             lookup_match;

    ////////////////////
    // Tag match

    always_comb begin
        fill_match   = 1'b0;
        fill_idx     = victim;
        lookup_match = 1'b0;
        lookup_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            // Refill of a present page reuses its slot
            if (valid[i] && tags[i] == fill_vpn) begin
                fill_match = 1'b1;
                fill_idx   = IDX_W'(i);
            end
            if (valid[i] && tags[i] == lookup_vpn) begin
                lookup_match = 1'b1;
                lookup_idx   = IDX_W'(i);
            end
        end
    end

    // Fills are ignored during the flush walk
    assign fill_do = fill_valid && !busy;

    ////////////////////
    // Flush walk

    // Busy for exactly DEPTH cycles starting the cycle after flush
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            flush_idx <= '0;
        end else if (busy) begin
            flush_idx <= flush_idx + 1'b1;
            if (flush_idx == IDX_W'(DEPTH - 1)) begin
                busy <= 1'b0;
            end
        end else if (flush) begin
            busy      <= 1'b1;
            flush_idx <= '0;
        end
    end

    // One entry invalidated per walk cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (busy) begin
            valid[flush_idx] <= 1'b0;
        end else if (fill_do) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    ////////////////////
    // Fill

    always_ff @(posedge clk) begin
        if (fill_do) begin
            tags[fill_idx] <= fill_vpn;
            data[fill_idx] <= fill_entry;
        end
    end

    // Pointer moves only when a new slot was taken
    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= '0;
        end else if (fill_do && !fill_match) begin
            victim <= victim + 1'b1;
        end
    end

    ////////////////////
    // Lookup

    // Result one cycle later, never a hit once a flush has started
    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= lookup_valid && lookup_match && !busy && !flush;
        end
    end

    always_ff @(posedge clk) begin
        entry <= data[lookup_idx];
    end

endmodule

`default_nettype wire

/* logic/gc_subsystem.sv */
// Control block top level; the issue source must hold issue_req while issue_stall is high
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_subsystem import gc_types_pkg::*, tlb_types_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // Pipeline and control
    input  logic        gc_req,
    input  gc_op_t      gc_op,
    input  logic        ls_issue,
    input  logic        ls_fifo_emptying,
    input  logic        ls_fifo_empty,
    // Table writes
    input  logic        issue_req,
    input  reg_addr_t   issue_rd,
    input  logic        wb_req,
    input  reg_addr_t   wb_rd,
    // Table reads
    input  reg_addr_t   rs1_addr,
    input  reg_addr_t   rs2_addr,
    output logic        rs1_busy,
    output logic        rs2_busy,
    // Instruction TLB
    input  logic        itlb_lookup_valid,
    input  vpn_t        itlb_vpn,
    input  logic        itlb_fill_valid,
    input  vpn_t        itlb_fill_vpn,
    input  itlb_entry_t itlb_fill_entry,
    output logic        itlb_hit,
    output itlb_entry_t itlb_entry,
    // Data TLB
    input  logic        dtlb_lookup_valid,
    input  vpn_t        dtlb_vpn,
    input  logic        dtlb_fill_valid,
    input  vpn_t        dtlb_fill_vpn,
    input  dtlb_entry_t dtlb_fill_entry,
    output logic        dtlb_hit,
    output dtlb_entry_t dtlb_entry,
    // Control outputs
    output logic        issue_stall,
    output logic        gc_ready,
    output logic        ecall,
    output logic        ebreak,
    output logic        sret,
    output logic        mret,
    output logic        fetch_flush,
    output logic        fetch_hold,
    output logic        issue_hold,
    output logic        inorder
);

    // Table write requesters
    inuse_wr_if clear_wr ();
    inuse_wr_if wb_wr ();
    inuse_wr_if issue_wr ();

    logic      wr_en;
    reg_addr_t wr_addr;
    logic      wr_value;

    logic      tlb_flush;
    logic      itlb_busy;
    logic      dtlb_busy;

    ////////////////////
    // Scoreboard requests

    // Writeback frees the register
    assign wb_wr.valid    = wb_req;
    assign wb_wr.addr     = wb_rd;
    assign wb_wr.value    = 1'b0;

    // Issue marks the destination busy
    assign issue_wr.valid = issue_req;
    assign issue_wr.addr  = issue_rd;
    assign issue_wr.value = 1'b1;

    assign issue_stall = issue_req && !issue_wr.grant;

    gc_unit u_gc_unit (
        .clk              (clk),
        .rst              (rst),
        .gc_req           (gc_req),
        .gc_op            (gc_op),
        .ls_issue         (ls_issue),
        .ls_fifo_emptying (ls_fifo_emptying),
        .ls_fifo_empty    (ls_fifo_empty),
        .itlb_busy        (itlb_busy),
        .dtlb_busy        (dtlb_busy),
        .gc_ready         (gc_ready),
        .ecall            (ecall),
        .ebreak           (ebreak),
        .sret             (sret),
        .mret             (mret),
        .fetch_flush      (fetch_flush),
        .fetch_hold       (fetch_hold),
        .issue_hold       (issue_hold),
        .inorder          (inorder),
        .inuse_clear      (),
        .tlb_flush        (tlb_flush),
        .clear_wr         (clear_wr.requester)
    );

    inuse_write_arbiter u_arbiter (
        .clear_wr (clear_wr.arbiter),
        .wb_wr    (wb_wr.arbiter),
        .issue_wr (issue_wr.arbiter),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_value (wr_value)
    );

    inuse_table u_inuse_table (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_value (wr_value),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy)
    );

    ////////////////////
    // Translation

    tlb #(.ENTRY_T(itlb_entry_t), .DEPTH(`GC_ITLB_DEPTH)) u_itlb (
        .clk          (clk),
        .rst          (rst),
        .flush        (tlb_flush),
        .lookup_valid (itlb_lookup_valid),
        .lookup_vpn   (itlb_vpn),
        .fill_valid   (itlb_fill_valid),
        .fill_vpn     (itlb_fill_vpn),
        .fill_entry   (itlb_fill_entry),
        .busy         (itlb_busy),
        .hit          (itlb_hit),
        .entry        (itlb_entry)
    );

    tlb #(.ENTRY_T(dtlb_entry_t), .DEPTH(`GC_DTLB_DEPTH)) u_dtlb (
        .clk          (clk),
        .rst          (rst),
        .flush        (tlb_flush),
        .lookup_valid (dtlb_lookup_valid),
        .lookup_vpn   (dtlb_vpn),
        .fill_valid   (dtlb_fill_valid),
        .fill_vpn     (dtlb_fill_vpn),
        .fill_entry   (dtlb_fill_entry),
        .busy         (dtlb_busy),
        .hit          (dtlb_hit),
        .entry        (dtlb_entry)
    );

endmodule

`default_nettype wire

/* test/gc_subsystem_tb.sv */
// Testbench for gc_subsystem; TLB pages come from a pool of 16 so evictions and refills occur
`timescale 1ns/1ps
`default_nettype none

`include "gc_params.svh"

module gc_subsystem_tb import gc_types_pkg::*, tlb_types_pkg::*; ();

    localparam int MAX_CYCLES = 3000;
    localparam int TLB_MAX = (`GC_ITLB_DEPTH > `GC_DTLB_DEPTH) ? `GC_ITLB_DEPTH : `GC_DTLB_DEPTH;

    logic clk = 1'b0;
    logic rst;
    logic gc_req, ls_issue, ls_fifo_emptying, ls_fifo_empty;
    gc_op_t gc_op;
    logic issue_req, wb_req;
    reg_addr_t issue_rd, wb_rd, rs1_addr, rs2_addr;
    logic rs1_busy, rs2_busy;
    logic itlb_lookup_valid, itlb_fill_valid, itlb_hit;
    vpn_t itlb_vpn, itlb_fill_vpn;
    itlb_entry_t itlb_fill_entry, itlb_entry;
    logic dtlb_lookup_valid, dtlb_fill_valid, dtlb_hit;
    vpn_t dtlb_vpn, dtlb_fill_vpn;
    dtlb_entry_t dtlb_fill_entry, dtlb_entry;
    logic issue_stall, gc_ready, ecall, ebreak, sret, mret;
    logic fetch_flush, fetch_hold, issue_hold, inorder;

    integer seed = 71390;
    int err_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    // Scoreboard comparison runs only while set
    logic chk_on = 1'b0;

    // Reference state
    logic busy_model [`GC_INUSE_DEPTH];
    vpn_t m_tag [2][8];
    logic [23:0] m_data [2][8];
    logic m_valid [2][8];
    int m_victim [2];

    gc_subsystem uut (.*);

    always #2 clk = ~clk;

    ////////////////////
    // Checking

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok) else begin
            err_count++;
            $display("[FAIL] %0t ns: %s", $time, msg);
        end
    endtask

    // Strobe set {ecall, ebreak, sret, mret, fetch_flush} one cycle after acceptance
    function automatic logic [4:0] expected_strobes(input gc_op_t op);
        case (op)
            OP_ECALL:  return 5'b10001;
            OP_EBREAK: return 5'b01001;
            OP_SRET:   return 5'b00101;
            OP_MRET:   return 5'b00011;
            OP_SFENCE: return 5'b00001;
            default:   return 5'b00000;
        endcase
    endfunction

    // Scoreboard model updated at the write edge and compared after it
    always @(posedge clk) begin
        if (chk_on && !rst) begin
            check(issue_stall == (issue_req && wb_req), "issue_stall differs from model");
            // Writeback outranks issue
            if (wb_req) begin
                busy_model[wb_rd] = 1'b0;
            end else if (issue_req) begin
                busy_model[issue_rd] = 1'b1;
            end
            #1;
            check(rs1_busy == busy_model[rs1_addr], "rs1_busy differs from model");
            check(rs2_busy == busy_model[rs2_addr], "rs2_busy differs from model");
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////
    // TLB reference

    function automatic int depth_of(input int t);
        return (t == 0) ? `GC_ITLB_DEPTH : `GC_DTLB_DEPTH;
    endfunction

    task automatic model_fill(input int t, input vpn_t vpn, input logic [23:0] payload);
        int slot;
        logic found;
        slot = m_victim[t];
        found = 1'b0;
        for (int i = 0; i < depth_of(t); i++) begin
            if (m_valid[t][i] && m_tag[t][i] == vpn) begin
                slot = i;
                found = 1'b1;
            end
        end
        m_valid[t][slot] = 1'b1;
        m_tag[t][slot] = vpn;
        m_data[t][slot] = payload;
        // Round robin only advances on a new slot
        if (!found) begin
            m_victim[t] = (m_victim[t] + 1) % depth_of(t);
        end
    endtask

    function automatic logic model_hit(input int t, input vpn_t vpn,
                                       output logic [23:0] payload);
        payload = '0;
        for (int i = 0; i < depth_of(t); i++) begin
            if (m_valid[t][i] && m_tag[t][i] == vpn) begin
                payload = m_data[t][i];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    ////////////////////
    // Stimulus tasks all entered on a falling edge

    task automatic reset_and_clear();
        int n;
        chk_on = 1'b0;
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        count_hold(n);
        check(n == `GC_INUSE_DEPTH + 1, $sformatf("issue_hold after reset lasted %0d", n));
        for (int i = 0; i < `GC_INUSE_DEPTH; i++) begin
            busy_model[i] = 1'b0;
        end
        chk_on = 1'b1;
    endtask

    // Cycles with issue_hold high until gc_ready returns
    task automatic count_hold(output int n);
        n = 0;
        while (!gc_ready) begin
            if (issue_hold) begin
                n++;
            end
            @(negedge clk);
        end
        // Hold drops on the edge that enters IDLE
        check(!issue_hold, "issue_hold still high once gc_ready rose");
    endtask

    task automatic read_sweep();
        for (int i = 0; i < `GC_INUSE_DEPTH; i++) begin
            rs1_addr = reg_addr_t'(i);
            rs2_addr = reg_addr_t'(`GC_INUSE_DEPTH - 1 - i);
            @(negedge clk);
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] r;
        for (int k = 0; k < cycles; k++) begin
            r = $random(seed);
            // A stalled issue keeps its request
            if (!issue_stall) begin
                issue_req = r[0];
                issue_rd = r[5:1];
            end
            wb_req = r[6];
            wb_rd = r[11:7];
            rs1_addr = r[16:12];
            rs2_addr = r[21:17];
            @(negedge clk);
        end
        wb_req = 1'b0;
        @(negedge clk);
        issue_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_op(input gc_op_t op);
        while (!gc_ready) begin
            @(negedge clk);
        end
        gc_req = 1'b1;
        gc_op = op;
        @(negedge clk);
        gc_req = 1'b0;
        check({ecall, ebreak, sret, mret, fetch_flush} == expected_strobes(op),
              $sformatf("strobes wrong after op %0d", op));
    endtask

    task automatic tlb_fill();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        itlb_fill_valid = 1'b1;
        itlb_fill_vpn = {16'h0040, r1[3:0]};
        itlb_fill_entry = itlb_entry_t'({r2[21:0], r2[22]});
        dtlb_fill_valid = 1'b1;
        dtlb_fill_vpn = {16'h0040, r1[7:4]};
        dtlb_fill_entry = dtlb_entry_t'({r3[21:0], r3[23:22]});
        model_fill(0, itlb_fill_vpn, {1'b0, itlb_fill_entry});
        model_fill(1, dtlb_fill_vpn, dtlb_fill_entry);
        @(negedge clk);
        itlb_fill_valid = 1'b0;
        dtlb_fill_valid = 1'b0;
    endtask

    task automatic tlb_lookup(input logic [3:0] pg);
        logic [23:0] ip;
        logic [23:0] dp;
        logic ih;
        logic dh;
        itlb_lookup_valid = 1'b1;
        itlb_vpn = {16'h0040, pg};
        dtlb_lookup_valid = 1'b1;
        dtlb_vpn = {16'h0040, pg};
        @(negedge clk);
        itlb_lookup_valid = 1'b0;
        dtlb_lookup_valid = 1'b0;
        ih = model_hit(0, itlb_vpn, ip);
        dh = model_hit(1, dtlb_vpn, dp);
        check(itlb_hit == ih, $sformatf("itlb hit wrong for page %0h", pg));
        check(dtlb_hit == dh, $sformatf("dtlb hit wrong for page %0h", pg));
        if (ih) begin
            check(itlb_entry == ip[22:0], $sformatf("itlb entry wrong for page %0h", pg));
        end
        if (dh) begin
            check(dtlb_entry == dp, $sformatf("dtlb entry wrong for page %0h", pg));
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        int n;
        rst = 1'b1;
        gc_req = 1'b0;
        gc_op = OP_ECALL;
        ls_issue = 1'b0;
        ls_fifo_emptying = 1'b0;
        ls_fifo_empty = 1'b1;
        issue_req = 1'b0;
        issue_rd = '0;
        wb_req = 1'b0;
        wb_rd = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        itlb_lookup_valid = 1'b0;
        itlb_vpn = '0;
        itlb_fill_valid = 1'b0;
        itlb_fill_vpn = '0;
        itlb_fill_entry = '0;
        dtlb_lookup_valid = 1'b0;
        dtlb_vpn = '0;
        dtlb_fill_valid = 1'b0;
        dtlb_fill_vpn = '0;
        dtlb_fill_entry = '0;
        for (int t = 0; t < 2; t++) begin
            m_victim[t] = 0;
            for (int i = 0; i < 8; i++) begin
                m_valid[t][i] = 1'b0;
            end
        end

        // Reset clear then preload all busy and clear again
        reset_and_clear();
        for (int i = 0; i < `GC_INUSE_DEPTH; i++) begin
            issue_req = 1'b1;
            issue_rd = reg_addr_t'(i);
            @(negedge clk);
        end
        issue_req = 1'b0;
        read_sweep();
        reset_and_clear();
        read_sweep();

        random_traffic(200);

        // Plain control strobes each followed by a quiet cycle
        for (int k = 0; k < 8; k++) begin
            send_op(gc_op_t'(k % 4));
            @(negedge clk);
            check({ecall, ebreak, sret, mret, fetch_flush} == 5'b0, "strobe longer than 1 cycle");
            check(gc_ready, "gc_ready low after control op");
        end

        // TLB fill, lookup, SFENCE walk, lookup, refill
        repeat (12) tlb_fill();
        for (int p = 0; p < 16; p++) begin
            tlb_lookup(p[3:0]);
        end
        send_op(OP_SFENCE);
        count_hold(n);
        check(n == TLB_MAX + 2, $sformatf("issue_hold during SFENCE lasted %0d", n));
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < 8; i++) begin
                m_valid[t][i] = 1'b0;
            end
        end
        for (int p = 0; p < 16; p++) begin
            tlb_lookup(p[3:0]);
        end
        repeat (6) tlb_fill();
        for (int p = 0; p < 16; p++) begin
            tlb_lookup(p[3:0]);
        end

        // FENCE with an empty FIFO returns at once
        send_op(OP_FENCE);
        check(!fetch_hold && gc_ready, "FENCE waited on an empty FIFO");
        // FENCE with pending loads and stores
        ls_fifo_empty = 1'b0;
        send_op(OP_FENCE);
        for (int k = 0; k < 5; k++) begin
            check(fetch_hold && !gc_ready, "fetch_hold low while FIFO not empty");
            @(negedge clk);
        end
        ls_fifo_empty = 1'b1;
        @(negedge clk);
        check(!fetch_hold && gc_ready, "fetch_hold stayed high after FIFO empty");

        // In-order window
        ls_issue = 1'b1;
        @(negedge clk);
        ls_issue = 1'b0;
        for (int k = 0; k < 4; k++) begin
            check(inorder && !gc_ready, "inorder low after load/store issue");
            @(negedge clk);
        end
        ls_fifo_emptying = 1'b1;
        @(negedge clk);
        ls_fifo_emptying = 1'b0;
        check(!inorder && gc_ready, "inorder stayed high after FIFO emptying");
        @(negedge clk);

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gc_subsystem.f */
+incdir+logic
logic/gc_types_pkg.sv
logic/tlb_types_pkg.sv
logic/gc_interfaces.sv
logic/gc_unit.sv
logic/inuse_write_arbiter.sv
logic/inuse_table.sv
logic/tlb.sv
logic/gc_subsystem.sv
test/gc_subsystem_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f gc_subsystem.f \
		--top-module gc_subsystem_tb -Mdir obj_dir -o gc_sim
	./obj_dir/gc_sim | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
